/* logic/mem_ui_pkg.sv */
// User-side protocol of the DDR controller.
package mem_ui_pkg;

  // Width of app_cmd.
  localparam int unsigned cmd_width = 3;

  // Only write and read are issued here.
  localparam logic [cmd_width-1:0] cmd_write = 3'd0;
  localparam logic [cmd_width-1:0] cmd_read  = 3'd1;

  // Beats per command on both the write and the read side.
  localparam int unsigned burst_beats = 2;

endpackage

/* logic/traffic_pkg.sv */
// Traffic pattern used by the exerciser.
package traffic_pkg;

  // Generator FSM states.
  typedef enum logic [1:0] {
    st_wr_wait,   // Write command posted.
    st_wr_first,  // First write beat on the bus.
    st_wr_last,   // Last write beat, app_wdf_end high.
    st_rd         // Read commands back to back.
  } gen_state_t;

  // Every pass starts here.
  localparam int unsigned start_addr = 0;

  // One burst apart.
  localparam int unsigned addr_step = 64;

endpackage

/* logic/ui_traffic_gen.sv */
module ui_traffic_gen
  import mem_ui_pkg::*, traffic_pkg::*;
#(
  parameter int ADDR_WIDTH = 27,
  parameter int DATA_WIDTH = 32,
  parameter int NUM_BURSTS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  app_rdy,
  output logic                  app_en,
  output logic [cmd_width-1:0]  app_cmd,
  output logic [ADDR_WIDTH-1:0] app_addr,
  input  logic                  app_wdf_rdy,
  output logic                  app_wdf_wren,
  output logic                  app_wdf_end,
  output logic [DATA_WIDTH-1:0] app_wdf_data,
  output logic                  state_error
);

  localparam int burst_width = (NUM_BURSTS > 1) ? $clog2(NUM_BURSTS) : 1;
  localparam int beat_width  = $clog2(burst_beats + 1);

  gen_state_t             state;
  logic [burst_width-1:0] burst_cnt;
  logic [beat_width-1:0]  beat_cnt;
  logic                   last_burst;
  logic                   cmd_done;

  assign last_burst = (burst_cnt == burst_width'(NUM_BURSTS - 1));
  // Low app_en in the wait state means the command already went through.
  assign cmd_done   = app_rdy || !app_en;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= st_wr_wait;
      app_en       <= 1'b1;  // First write pending right away.
      app_cmd      <= cmd_write;
      app_addr     <= ADDR_WIDTH'(start_addr);
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b0;
      app_wdf_data <= '0;
      burst_cnt    <= '0;
      beat_cnt     <= '0;
      state_error  <= 1'b0;
    end else begin
      case (state)
        st_wr_wait: begin
          if (cmd_done && app_wdf_rdy) begin
            app_en       <= 1'b0;
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            app_wdf_data <= app_wdf_data + DATA_WIDTH'(1);
            beat_cnt     <= beat_width'(1);
            state        <= st_wr_first;
          end else if (app_en && app_rdy) begin
            app_en <= 1'b0;  // Command taken while the write FIFO is full.
          end
        end
        st_wr_first: begin
          if (app_wdf_rdy) begin
            app_wdf_data <= app_wdf_data + DATA_WIDTH'(1);
            beat_cnt     <= beat_cnt + beat_width'(1);
            if (beat_cnt == beat_width'(burst_beats - 1)) begin
              app_wdf_end <= 1'b1;
              state       <= st_wr_last;
            end
          end
        end
        st_wr_last: begin
          if (app_wdf_rdy) begin
            app_wdf_wren <= 1'b0;
            app_wdf_end  <= 1'b0;
            app_en       <= 1'b1;
            if (last_burst) begin
              app_addr  <= ADDR_WIDTH'(start_addr);
              app_cmd   <= cmd_read;
              burst_cnt <= '0;
              state     <= st_rd;
            end else begin
              app_addr  <= app_addr + ADDR_WIDTH'(addr_step);
              app_cmd   <= cmd_write;
              burst_cnt <= burst_cnt + burst_width'(1);
              state     <= st_wr_wait;
            end
          end
        end
        st_rd: begin
          // One read per accepted cycle with many in flight.
          if (app_rdy) begin
            if (last_burst) begin
              app_addr  <= ADDR_WIDTH'(start_addr);
              app_cmd   <= cmd_write;
              burst_cnt <= '0;
              state     <= st_wr_wait;
            end else begin
              app_addr  <= app_addr + ADDR_WIDTH'(addr_step);
              burst_cnt <= burst_cnt + burst_width'(1);
            end
          end
        end
        default: begin
          app_en       <= 1'b0;
          app_wdf_wren <= 1'b0;
          app_wdf_end  <= 1'b0;
          state_error  <= 1'b1;  // Sticky until reset.
        end
      endcase
    end
  end

  end_has_wren: assert property (
    @(posedge clk) disable iff (reset)
    app_wdf_end |-> app_wdf_wren
  ) else $error("app_wdf_end without app_wdf_wren");

  // Command held while the controller stalls it.
  cmd_held: assert property (
    @(posedge clk) disable iff (reset)
    (app_en && !app_rdy) |=> ($stable(app_cmd) && $stable(app_addr))
  ) else $error("command changed while stalled");

endmodule

/* logic/rd_data_checker.sv */
module rd_data_checker
  import mem_ui_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int NUM_BURSTS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  app_rd_data_valid,
  input  logic [DATA_WIDTH-1:0] app_rd_data,
  output logic                  data_error,
  output logic                  pass_done
);

  localparam int pass_beats = NUM_BURSTS * burst_beats;
  localparam int cnt_width  = (pass_beats > 1) ? $clog2(pass_beats) : 1;

  logic [DATA_WIDTH-1:0] exp_data;
  logic [cnt_width-1:0]  beat_cnt;
  logic                  last_beat;

  assign last_beat = (beat_cnt == cnt_width'(pass_beats - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      exp_data   <= DATA_WIDTH'(1);  // Pattern starts at 1.
      beat_cnt   <= '0;
      data_error <= 1'b0;
      pass_done  <= 1'b0;
    end else begin
      pass_done <= app_rd_data_valid && last_beat;
      if (app_rd_data_valid) begin
        exp_data <= exp_data + DATA_WIDTH'(1);
        if (app_rd_data != exp_data) begin
          data_error <= 1'b1;  // Sticky.
        end
        if (last_beat) begin
          beat_cnt <= '0;
        end else begin
          beat_cnt <= beat_cnt + cnt_width'(1);
        end
      end
    end
  end

  // A pass is always more than one beat long.
  single_pass_pulse: assert property (
    @(posedge clk) disable iff (reset)
    pass_done |=> !pass_done
  ) else $error("pass_done high on consecutive cycles");

endmodule

/* logic/mem_exerciser.sv */
module mem_exerciser
  import mem_ui_pkg::*;
#(
  parameter int ADDR_WIDTH = 27,
  parameter int DATA_WIDTH = 32,
  parameter int NUM_BURSTS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  app_rdy,
  output logic                  app_en,
  output logic [cmd_width-1:0]  app_cmd,
  output logic [ADDR_WIDTH-1:0] app_addr,
  input  logic                  app_wdf_rdy,
  output logic                  app_wdf_wren,
  output logic                  app_wdf_end,
  output logic [DATA_WIDTH-1:0] app_wdf_data,
  input  logic                  app_rd_data_valid,
  input  logic [DATA_WIDTH-1:0] app_rd_data,
  output logic                  error,
  output logic                  pass_done
);

  logic state_error;
  logic data_error;

  ui_traffic_gen #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_BURSTS (NUM_BURSTS)
  ) u_gen (
    .clk          (clk),
    .reset        (reset),
    .app_rdy      (app_rdy),
    .app_en       (app_en),
    .app_cmd      (app_cmd),
    .app_addr     (app_addr),
    .app_wdf_rdy  (app_wdf_rdy),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .app_wdf_data (app_wdf_data),
    .state_error  (state_error)
  );

  rd_data_checker #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_BURSTS (NUM_BURSTS)
  ) u_chk (
    .clk               (clk),
    .reset             (reset),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data),
    .data_error        (data_error),
    .pass_done         (pass_done)
  );

  assign error = state_error | data_error;  // Both flags already sticky.

endmodule

/* verification/ui_mem_model.sv */
module ui_mem_model
  import mem_ui_pkg::*;
#(
  parameter int ADDR_WIDTH   = 27,
  parameter int DATA_WIDTH   = 32,
  parameter int READ_LATENCY = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  app_en,
  input  logic [cmd_width-1:0]  app_cmd,
  input  logic [ADDR_WIDTH-1:0] app_addr,
  output logic                  app_rdy,
  input  logic                  app_wdf_wren,
  input  logic                  app_wdf_end,
  input  logic [DATA_WIDTH-1:0] app_wdf_data,
  output logic                  app_wdf_rdy,
  output logic                  app_rd_data_valid,
  output logic [DATA_WIDTH-1:0] app_rd_data,
  input  logic                  inject,
  output logic                  fault_beat
);

  int                    seed = 49;
  logic                  rdy_q = 1'b0;
  logic                  wdf_rdy_q = 1'b0;
  logic                  valid_q = 1'b0;
  logic [DATA_WIDTH-1:0] data_q = '0;
  logic                  fault_q = 1'b0;
  logic                  armed = 1'b0;
  logic [DATA_WIDTH-1:0] mem [int];  // Keyed by address and beat.
  int                    wr_addr_q [$];
  logic [DATA_WIDTH-1:0] rd_data_q [$];
  longint                rd_due_q [$];
  longint                cycle = 0;
  int                    wr_beat = 0;
  int                    key;
  int                    b;

  assign app_rdy           = rdy_q;
  assign app_wdf_rdy       = wdf_rdy_q;
  assign app_rd_data_valid = valid_q;
  assign app_rd_data       = data_q;
  assign fault_beat        = fault_q;

  always @(posedge clk) begin
    if (reset) begin
      rdy_q     <= 1'b0;
      wdf_rdy_q <= 1'b0;
      valid_q   <= 1'b0;
      fault_q   <= 1'b0;
      armed      = 1'b0;
      cycle      = 0;
      wr_beat    = 0;
      wr_addr_q.delete();
      rd_data_q.delete();
      rd_due_q.delete();
    end else begin
      cycle      = cycle + 1;
      rdy_q     <= ($random(seed) % 4) != 0;  // Stall one cycle in four.
      wdf_rdy_q <= ($random(seed) % 4) != 0;
      if (inject) begin
        armed = 1'b1;
      end
      if (app_en && app_rdy) begin
        if (app_cmd == cmd_write) begin
          wr_addr_q.push_back(int'(app_addr));
        end else begin
          // Data captured at accept so later writes cannot race it.
          for (b = 0; b < burst_beats; b++) begin
            key = int'(app_addr) * burst_beats + b;
            rd_data_q.push_back(mem.exists(key) ? mem[key] : '0);
            rd_due_q.push_back(cycle + READ_LATENCY);
          end
        end
      end
      if (app_wdf_wren && app_wdf_rdy && wr_addr_q.size() > 0) begin
        key      = wr_addr_q[0] * burst_beats + wr_beat;
        mem[key] = app_wdf_data;
        wr_beat  = wr_beat + 1;
        if (app_wdf_end) begin
          wr_addr_q.pop_front();
          wr_beat = 0;
        end
      end
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
        valid_q <= 1'b1;
        data_q  <= armed ? (rd_data_q[0] ^ DATA_WIDTH'(1)) : rd_data_q[0];
        fault_q <= armed;
        armed    = 1'b0;
        rd_data_q.pop_front();
        rd_due_q.pop_front();
      end else begin
        valid_q <= 1'b0;
        fault_q <= 1'b0;
      end
    end
  end

endmodule

/* verification/tb_mem_exerciser.sv */
module tb_mem_exerciser
  import mem_ui_pkg::*, traffic_pkg::*;
();

  localparam int ADDR_WIDTH     = 27;
  localparam int DATA_WIDTH     = 32;
  localparam int NUM_BURSTS     = 4;
  localparam int pass_beats     = NUM_BURSTS * burst_beats;
  localparam int timeout_cycles = 4 * NUM_BURSTS * 20 + 200;
  localparam int num_tests      = 6;

  logic                  clk;
  logic                  reset;
  logic                  app_rdy;
  logic                  app_en;
  logic [cmd_width-1:0]  app_cmd;
  logic [ADDR_WIDTH-1:0] app_addr;
  logic                  app_wdf_rdy;
  logic                  app_wdf_wren;
  logic                  app_wdf_end;
  logic [DATA_WIDTH-1:0] app_wdf_data;
  logic                  app_rd_data_valid;
  logic [DATA_WIDTH-1:0] app_rd_data;
  logic                  error;
  logic                  pass_done;
  logic                  inject;
  logic                  fault_beat;
  logic                  fault_sent;

  // Scoreboard counted from the pattern rules.
  int                    cmd_idx;
  logic                  first_seen;
  int                    beat_total;
  int                    rd_total;
  int                    pass_count;
  logic                  exp_pass;
  logic [DATA_WIDTH-1:0] exp_wdata;
  logic                  end_due;
  logic [ADDR_WIDTH-1:0] exp_addr;
  logic [cmd_width-1:0]  exp_cmd;
  int                    hits [num_tests];
  int                    errs [num_tests];
  int                    cycles = 0;
  int                    tests_failed = 0;
  int                    total_errs = 0;

  mem_exerciser #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_BURSTS (NUM_BURSTS)
  ) dut (.*);

  ui_mem_model #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_model (.*);

  assign exp_wdata = DATA_WIDTH'(beat_total + 1);
  assign end_due   = (beat_total % burst_beats) == burst_beats - 1;
  assign exp_addr  = ADDR_WIDTH'(start_addr + (cmd_idx % NUM_BURSTS) * addr_step);
  assign exp_cmd   = (cmd_idx < NUM_BURSTS) ? cmd_write : cmd_read;  // Writes before reads.

  function automatic string test_name(input int t);
    case (t)
      0:       return "first_command";
      1:       return "write_data";
      2:       return "cmd_sequence";
      3:       return "stall_hold";
      4:       return "clean_passes";
      default: return "fault_detect";
    endcase
  endfunction

  task automatic value_error(input int t, input logic [63:0] exp_v, input logic [63:0] act_v);
    errs[t]++;
    $display("ERR %s: expected %0h, actual %0h", test_name(t), exp_v, act_v);
  endtask

  task automatic plain_error(input int t, input string what);
    errs[t]++;
    $display("%s: %s", test_name(t), what);
  endtask

  task automatic report_test(input int t);
    if (hits[t] == 0) begin
      tests_failed++;
      $display("%s: never reached", test_name(t));
    end else if (errs[t] > 0) begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name(t), errs[t]);
    end else begin
      $display("%s: ok, %0d checks", test_name(t), hits[t]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      cmd_idx    <= 0;
      first_seen <= 1'b0;
      beat_total <= 0;
      rd_total   <= 0;
      exp_pass   <= 1'b0;
      pass_count <= 0;
    end else begin
      if (app_en && app_rdy) begin
        cmd_idx    <= (cmd_idx + 1) % (2 * NUM_BURSTS);
        first_seen <= 1'b1;
        hits[2]    <= hits[2] + 1;
        if (!first_seen) begin
          hits[0] <= hits[0] + 1;
        end
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        beat_total <= beat_total + 1;
        hits[1]    <= hits[1] + 1;
      end
      if (app_en && !app_rdy) begin
        hits[3] <= hits[3] + 1;
      end
      exp_pass <= app_rd_data_valid && (rd_total % pass_beats == pass_beats - 1);
      if (app_rd_data_valid) begin
        rd_total <= rd_total + 1;
      end
      if (pass_done) begin
        pass_count <= pass_count + 1;
        hits[4]    <= hits[4] + 1;
      end
      if (fault_beat) begin
        hits[5] <= hits[5] + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  first_addr: assert property (@(posedge clk) disable iff (reset)
    (app_en && app_rdy && !first_seen) |-> app_addr == ADDR_WIDTH'(start_addr))
    else value_error(0, 64'(start_addr), 64'($sampled(app_addr)));
  first_cmd: assert property (@(posedge clk) disable iff (reset)
    (app_en && app_rdy && !first_seen) |-> app_cmd == cmd_write)
    else value_error(0, 64'(cmd_write), 64'($sampled(app_cmd)));
  en_at_release: assert property (@(posedge clk) $fell(reset) |-> app_en)
    else plain_error(0, "app_en low as reset was released");

  wr_value: assert property (@(posedge clk) disable iff (reset)
    (app_wdf_wren && app_wdf_rdy) |-> app_wdf_data == exp_wdata)
    else value_error(1, 64'($sampled(exp_wdata)), 64'($sampled(app_wdf_data)));
  wr_end: assert property (@(posedge clk) disable iff (reset)
    (app_wdf_wren && app_wdf_rdy) |-> app_wdf_end == end_due)
    else value_error(1, 64'($sampled(end_due)), 64'($sampled(app_wdf_end)));
  end_in_beat: assert property (@(posedge clk) disable iff (reset)
    app_wdf_end |-> app_wdf_wren)
    else plain_error(1, "app_wdf_end high without app_wdf_wren");

  cmd_addr: assert property (@(posedge clk) disable iff (reset)
    (app_en && app_rdy) |-> app_addr == exp_addr)
    else value_error(2, 64'($sampled(exp_addr)), 64'($sampled(app_addr)));
  cmd_code: assert property (@(posedge clk) disable iff (reset)
    (app_en && app_rdy) |-> app_cmd == exp_cmd)
    else value_error(2, 64'($sampled(exp_cmd)), 64'($sampled(app_cmd)));
  rd_state: assert property (@(posedge clk) disable iff (reset)
    (dut.u_gen.state == st_rd) |-> (app_en && app_cmd == cmd_read))
    else plain_error(2, "read state without a pending read command");

  stall_stable: assert property (@(posedge clk) disable iff (reset)
    (app_en && !app_rdy) |=> ($stable(app_cmd) && $stable(app_addr)))
    else plain_error(3, "command or address changed while stalled");

  clean_error: assert property (@(posedge clk) disable iff (reset)
    !fault_sent |-> !error)
    else value_error(4, 64'(0), 64'($sampled(error)));
  pass_pulse: assert property (@(posedge clk) disable iff (reset)
    pass_done == exp_pass)
    else value_error(4, 64'($sampled(exp_pass)), 64'($sampled(pass_done)));

  fault_seen: assert property (@(posedge clk) disable iff (reset)
    fault_beat |=> error)
    else value_error(5, 64'(1), 64'($sampled(error)));
  error_sticky: assert property (@(posedge clk) disable iff (reset)
    error |=> error)
    else plain_error(5, "error dropped before the end of the run");

  initial begin
    reset      = 1'b1;
    inject     = 1'b0;
    fault_sent = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    while (hits[0] == 0) @(posedge clk);
    report_test(0);
    while (pass_count < 3) @(posedge clk);
    report_test(4);
    // Corrupt the first read beat of the fourth pass.
    @(posedge clk);
    inject     <= 1'b1;
    fault_sent <= 1'b1;
    @(posedge clk);
    inject <= 1'b0;
    while (!error) @(posedge clk);
    repeat (2 * pass_beats) @(posedge clk);
    report_test(1);
    report_test(2);
    report_test(3);
    report_test(5);
    foreach (errs[t]) begin
      total_errs += errs[t];
    end
    $display("summary: %0d tests, %0d failed, %0d check errors",
             num_tests, tests_failed, total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/mem_ui_pkg.sv
logic/traffic_pkg.sv
logic/ui_traffic_gen.sv
logic/rd_data_checker.sv
logic/mem_exerciser.sv
verification/ui_mem_model.sv
verification/tb_mem_exerciser.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run, status follows the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mem_exerciser -f tb.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep "Testbench passed" > /dev/null &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }
